// File: rtl/ae_defs.svh
`ifndef AE_DEFS_SVH
`define AE_DEFS_SVH

// control stream geometry
`define AE_CTRL_DATA_W 512
`define AE_CTRL_USER_W 128

// packet header vector and vlan id
`define AE_PHV_LEN 1024
`define AE_VLAN_W 12
`define AE_VLAN_LSB 129

// page table shape
`define AE_PAGE_W 16
`define AE_PAGE_DEPTH 32
// vlan id bit where the table address starts
`define AE_PAGE_ADDR_LSB 4

// header beat fields, low bit of each
`define AE_MOD_ID_LSB 368
`define AE_FLAG_LSB 320
`define AE_INDEX_LSB 384
`define AE_CTRL_FLAG 16'hf2f1

`endif

// File: rtl/ae_pkg.sv
`default_nettype none

`include "ae_defs.svh"

package ae_pkg;

    typedef logic [`AE_CTRL_DATA_W-1:0] ctrl_data_t;
    typedef logic [`AE_CTRL_USER_W-1:0] ctrl_user_t;
    // one enable per data byte
    typedef logic [`AE_CTRL_DATA_W/8-1:0] ctrl_keep_t;

    // one control stream beat, valid travels beside it
    typedef struct packed {
        ctrl_data_t data;
        ctrl_user_t user;
        ctrl_keep_t keep;
        logic       last;
    } ctrl_beat_t;

    typedef logic [`AE_PHV_LEN-1:0] phv_t;
    typedef logic [`AE_VLAN_W-1:0] vlan_id_t;
    typedef logic [`AE_PAGE_W-1:0] page_t;
    typedef logic [$clog2(`AE_PAGE_DEPTH)-1:0] page_addr_t;
    typedef logic [7:0] tbl_index_t;

    typedef enum logic [1:0] {CTRL_IDLE, CTRL_WRITE_FIRST, CTRL_WRITE_NEXT} ctrl_state_e;
    typedef enum logic {VLAN_IDLE, VLAN_HOLD} vlan_state_e;
    typedef enum logic {LKUP_IDLE, LKUP_READ} lookup_state_e;

endpackage

`default_nettype wire

// File: rtl/ctrl_write_parser.sv
`timescale 1ns/1ps
`default_nettype none

`include "ae_defs.svh"

module ctrl_write_parser
    import ae_pkg::*;
#(
    parameter logic [4:0] STAGE_ID  = 5'd0,
    parameter logic [2:0] ACTION_ID = 3'd3
) (
    input  wire             clk,
    input  wire             rst_n,

    // control stream in
    input  wire ctrl_beat_t ctrl_s_i,
    input  wire             ctrl_s_valid_i,

    // control stream out, foreign packets only
    output ctrl_beat_t      ctrl_m_o,
    output logic            ctrl_m_valid_o,

    // table write port
    output logic            wr_en_o,
    output page_addr_t      wr_addr_o,
    output page_t           wr_data_o
);

    logic [7:0]  mod_id;
    logic [15:0] ctrl_flag;
    logic        hdr_match;
    page_t       beat_entry;
    tbl_index_t  idx_q;
    ctrl_state_e state_q;

    // header fields
    assign mod_id    = ctrl_s_i.data[`AE_MOD_ID_LSB +: 8];
    assign ctrl_flag = ctrl_s_i.data[`AE_FLAG_LSB +: 16];

    // upper five bits of the module id select the stage, lower three the action
    assign hdr_match = ctrl_s_valid_i
                    && (mod_id[7:3] == STAGE_ID)
                    && (mod_id[2:0] == ACTION_ID)
                    && (ctrl_flag == `AE_CTRL_FLAG);

    // stream is little endian, byte 0 lands in the high byte
    assign beat_entry = {ctrl_s_i.data[7:0], ctrl_s_i.data[15:8]};

    // index register doubles as the write address
    assign wr_addr_o = idx_q[$bits(page_addr_t)-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q        <= CTRL_IDLE;
            idx_q          <= '0;
            ctrl_m_o       <= '0;
            ctrl_m_valid_o <= 1'b0;
            wr_en_o        <= 1'b0;
            wr_data_o      <= '0;
        end else begin
            ctrl_m_valid_o <= 1'b0;
            wr_en_o        <= 1'b0;

            case (state_q)
                CTRL_IDLE: begin
                    if (hdr_match) begin
                        // header is swallowed, keep its start index
                        idx_q   <= ctrl_s_i.data[`AE_INDEX_LSB +: $bits(tbl_index_t)];
                        state_q <= CTRL_WRITE_FIRST;
                    end else if (ctrl_s_valid_i) begin
                        ctrl_m_o       <= ctrl_s_i;
                        ctrl_m_valid_o <= 1'b1;
                    end
                end

                // first data beat writes at the header index
                CTRL_WRITE_FIRST: begin
                    if (ctrl_s_valid_i) begin
                        wr_en_o   <= 1'b1;
                        wr_data_o <= beat_entry;
                        if (ctrl_s_i.last) begin
                            state_q <= CTRL_IDLE;
                        end else begin
                            state_q <= CTRL_WRITE_NEXT;
                        end
                    end
                end

                // later beats fill consecutive entries
                CTRL_WRITE_NEXT: begin
                    if (ctrl_s_valid_i) begin
                        wr_en_o   <= 1'b1;
                        wr_data_o <= beat_entry;
                        idx_q     <= idx_q + 1'b1;
                        if (ctrl_s_i.last) begin
                            state_q <= CTRL_IDLE;
                        end
                    end
                end

                default: begin
                    state_q <= CTRL_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/page_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "ae_defs.svh"

module page_table
    import ae_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,

    // write port from the control parser
    input  wire        wr_en_i,
    input  wire page_addr_t wr_addr_i,
    input  wire page_t wr_data_i,

    // lookup request
    input  wire vlan_id_t lookup_vlan_i,
    input  wire        lookup_valid_i,
    output logic       lookup_ready_o,

    // lookup result
    output page_t      page_o,
    output logic       page_valid_o
);

    page_t         mem [`AE_PAGE_DEPTH];
    page_addr_t    rd_addr_q;
    logic          rd_pend_q;
    lookup_state_e state_q;

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // accept, read one edge later, report on the edge after that
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q        <= LKUP_IDLE;
            rd_addr_q      <= '0;
            rd_pend_q      <= 1'b0;
            lookup_ready_o <= 1'b1;
            page_o         <= '0;
            page_valid_o   <= 1'b0;
        end else begin
            rd_pend_q    <= 1'b0;
            page_valid_o <= rd_pend_q;
            if (rd_pend_q) begin
                lookup_ready_o <= 1'b1;
            end

            case (state_q)
                LKUP_IDLE: begin
                    if (lookup_valid_i && lookup_ready_o) begin
                        rd_addr_q      <= lookup_vlan_i[`AE_PAGE_ADDR_LSB +: $bits(page_addr_t)];
                        lookup_ready_o <= 1'b0;
                        state_q        <= LKUP_READ;
                    end
                end
                LKUP_READ: begin
                    // a same-edge write to this address is not yet visible
                    page_o    <= mem[rd_addr_q];
                    rd_pend_q <= 1'b1;
                    state_q   <= LKUP_IDLE;
                end
                default: begin
                    state_q <= LKUP_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/vlan_extract.sv
`timescale 1ns/1ps
`default_nettype none

`include "ae_defs.svh"

module vlan_extract
    import ae_pkg::*;
(
    input  wire       clk,
    input  wire       rst_n,

    input  wire phv_t phv_i,
    input  wire       phv_valid_i,

    output vlan_id_t  vlan_o,
    output logic      vlan_valid_o,
    input  wire       vlan_ready_i
);

    vlan_state_e state_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= VLAN_IDLE;
            vlan_o       <= '0;
            vlan_valid_o <= 1'b0;
        end else begin
            vlan_valid_o <= 1'b0;

            case (state_q)
                VLAN_IDLE: begin
                    if (phv_valid_i) begin
                        vlan_o  <= phv_i[`AE_VLAN_LSB +: `AE_VLAN_W];
                        state_q <= VLAN_HOLD;
                    end
                end
                // new phvs are dropped until downstream takes this one
                VLAN_HOLD: begin
                    if (vlan_ready_i) begin
                        vlan_valid_o <= 1'b1;
                        state_q      <= VLAN_IDLE;
                    end
                end
                default: begin
                    state_q <= VLAN_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/action_engine.sv
`timescale 1ns/1ps
`default_nettype none

module action_engine
    import ae_pkg::*;
#(
    parameter logic [4:0] STAGE_ID  = 5'd0,
    parameter logic [2:0] ACTION_ID = 3'd3
) (
    input  wire             clk,
    input  wire             rst_n,

    // control path
    input  wire ctrl_beat_t ctrl_s_i,
    input  wire             ctrl_s_valid_i,
    output ctrl_beat_t      ctrl_m_o,
    output logic            ctrl_m_valid_o,

    // page lookup
    input  wire vlan_id_t   lookup_vlan_i,
    input  wire             lookup_valid_i,
    output logic            lookup_ready_o,
    output page_t           page_o,
    output logic            page_valid_o,

    // vlan extraction
    input  wire phv_t       phv_i,
    input  wire             phv_valid_i,
    output vlan_id_t        vlan_o,
    output logic            vlan_valid_o,
    input  wire             vlan_ready_i
);

    logic       wr_en;
    page_addr_t wr_addr;
    page_t      wr_data;

    ctrl_write_parser #(
        .STAGE_ID  (STAGE_ID),
        .ACTION_ID (ACTION_ID)
    ) u_parser (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl_s_i       (ctrl_s_i),
        .ctrl_s_valid_i (ctrl_s_valid_i),
        .ctrl_m_o       (ctrl_m_o),
        .ctrl_m_valid_o (ctrl_m_valid_o),
        .wr_en_o        (wr_en),
        .wr_addr_o      (wr_addr),
        .wr_data_o      (wr_data)
    );

    // filled by the parser, read by vlan lookups
    page_table u_table (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_en_i        (wr_en),
        .wr_addr_i      (wr_addr),
        .wr_data_i      (wr_data),
        .lookup_vlan_i  (lookup_vlan_i),
        .lookup_valid_i (lookup_valid_i),
        .lookup_ready_o (lookup_ready_o),
        .page_o         (page_o),
        .page_valid_o   (page_valid_o)
    );

    vlan_extract u_vlan (
        .clk          (clk),
        .rst_n        (rst_n),
        .phv_i        (phv_i),
        .phv_valid_i  (phv_valid_i),
        .vlan_o       (vlan_o),
        .vlan_valid_o (vlan_valid_o),
        .vlan_ready_i (vlan_ready_i)
    );

endmodule

`default_nettype wire

// File: sim/tb_action_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_action_engine
    import ae_pkg::*;
();

    localparam logic [4:0]  STAGE     = 5'd2;
    localparam logic [2:0]  ACTION    = 3'd5;
    localparam logic [7:0]  MATCH_ID  = {STAGE, ACTION};
    localparam logic [15:0] CTRL_FLAG = 16'hf2f1;
    localparam int MOD_LSB   = 368;
    localparam int FLAG_LSB  = 320;
    localparam int INDEX_LSB = 384;
    localparam int VLAN_LSB  = 129;
    localparam int ADDR_LSB  = 4;
    localparam int NUM_STEPS = 15;

    typedef enum logic [2:0] {S_IDLE, S_BYPASS, S_WRITE, S_LOOKUP, S_PHV} step_kind_e;

    // count is data beats, lookups, hold cycles or idle cycles depending on kind
    typedef struct packed {
        step_kind_e  kind;
        logic [7:0]  count;
        logic [7:0]  mod_id;
        logic [15:0] flag;
        logic        exp_fwd;
    } step_t;

    logic       clk;
    logic       rst_n;
    ctrl_beat_t ctrl_s_i;
    logic       ctrl_s_valid_i;
    ctrl_beat_t ctrl_m_o;
    logic       ctrl_m_valid_o;
    vlan_id_t   lookup_vlan_i;
    logic       lookup_valid_i;
    logic       lookup_ready_o;
    page_t      page_o;
    logic       page_valid_o;
    phv_t       phv_i;
    logic       phv_valid_i;
    vlan_id_t   vlan_o;
    logic       vlan_valid_o;
    logic       vlan_ready_i;

    step_t       steps [NUM_STEPS];
    page_t       model [32];
    logic [4:0]  written_q [$];
    logic [31:0] lfsr_q = 32'had4a0d11;

    action_engine #(
        .STAGE_ID  (STAGE),
        .ACTION_ID (ACTION)
    ) u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl_s_i       (ctrl_s_i),
        .ctrl_s_valid_i (ctrl_s_valid_i),
        .ctrl_m_o       (ctrl_m_o),
        .ctrl_m_valid_o (ctrl_m_valid_o),
        .lookup_vlan_i  (lookup_vlan_i),
        .lookup_valid_i (lookup_valid_i),
        .lookup_ready_o (lookup_ready_o),
        .page_o         (page_o),
        .page_valid_o   (page_valid_o),
        .phv_i          (phv_i),
        .phv_valid_i    (phv_valid_i),
        .vlan_o         (vlan_o),
        .vlan_valid_o   (vlan_valid_o),
        .vlan_ready_i   (vlan_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (NUM_STEPS * 40 + 100) @(posedge clk);
        $display("timeout: the test sequence did not complete in time");
        $display("STATUS: FAIL");
        $fatal(1);
    end

    // galois lfsr, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic next_rand_bit();
        logic out;
        out = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out) begin
            lfsr_q = lfsr_q ^ 32'h80200003;
        end
        return out;
    endfunction

    task automatic rand_vec(output logic [1023:0] v, input int n);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v[i] = next_rand_bit();
        end
    endtask

    task automatic compare(input string name, input logic [1023:0] got,
                           input logic [1023:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    function automatic step_t mk(input step_kind_e kind, input int count,
                                 input logic [7:0] mod_id, input logic [15:0] flag,
                                 input logic exp_fwd);
        step_t s;
        s.kind    = kind;
        s.count   = count[7:0];
        s.mod_id  = mod_id;
        s.flag    = flag;
        s.exp_fwd = exp_fwd;
        return s;
    endfunction

    task automatic build_table();
        steps[0]  = mk(S_IDLE, 2, 8'h00, 16'h0000, 1'b0);
        // wrong flag, wrong stage, wrong action
        steps[1]  = mk(S_BYPASS, 2, MATCH_ID, 16'hf2f0, 1'b1);
        steps[2]  = mk(S_BYPASS, 1, {STAGE + 5'd1, ACTION}, CTRL_FLAG, 1'b1);
        steps[3]  = mk(S_BYPASS, 3, {STAGE, ACTION ^ 3'd1}, CTRL_FLAG, 1'b1);
        steps[4]  = mk(S_WRITE, 1, MATCH_ID, CTRL_FLAG, 1'b0);
        steps[5]  = mk(S_WRITE, 4, MATCH_ID, CTRL_FLAG, 1'b0);
        steps[6]  = mk(S_WRITE, 2, MATCH_ID, CTRL_FLAG, 1'b0);
        steps[7]  = mk(S_WRITE, 3, MATCH_ID, CTRL_FLAG, 1'b0);
        steps[8]  = mk(S_LOOKUP, 10, 8'h00, 16'h0000, 1'b0);
        steps[9]  = mk(S_PHV, 4, 8'h00, 16'h0000, 1'b0);
        steps[10] = mk(S_WRITE, 4, MATCH_ID, CTRL_FLAG, 1'b0);
        steps[11] = mk(S_BYPASS, 1, {~STAGE, ACTION}, CTRL_FLAG, 1'b1);
        steps[12] = mk(S_LOOKUP, 4, 8'h00, 16'h0000, 1'b0);
        steps[13] = mk(S_PHV, 2, 8'h00, 16'h0000, 1'b0);
        steps[14] = mk(S_IDLE, 3, 8'h00, 16'h0000, 1'b0);
    endtask

    task automatic check_beat(input logic exp_fwd, input ctrl_beat_t b);
        compare("ctrl_m_valid_o", ctrl_m_valid_o, exp_fwd);
        if (exp_fwd) begin
            compare("ctrl_m_o.data", ctrl_m_o.data, b.data);
            compare("ctrl_m_o.user", ctrl_m_o.user, b.user);
            compare("ctrl_m_o.keep", ctrl_m_o.keep, b.keep);
            compare("ctrl_m_o.last", ctrl_m_o.last, b.last);
        end
    endtask

    // header beat plus count data beats, one beat per cycle
    task automatic run_packet(input step_t s);
        ctrl_beat_t    beats [$];
        ctrl_beat_t    b;
        logic [1023:0] r;
        logic [7:0]    idx;
        logic [4:0]    addr;
        int            i;
        rand_vec(r, 8);
        idx = r[7:0];
        for (i = 0; i <= s.count; i++) begin
            rand_vec(r, 512);
            b.data = r[511:0];
            rand_vec(r, 128);
            b.user = r[127:0];
            rand_vec(r, 64);
            b.keep = r[63:0];
            b.last = (i == s.count);
            if (i == 0) begin
                b.data[MOD_LSB +: 8]   = s.mod_id;
                b.data[FLAG_LSB +: 16] = s.flag;
                b.data[INDEX_LSB +: 8] = idx;
            end else begin
                b.data[FLAG_LSB +: 16] = 16'h0000;
            end
            beats.push_back(b);
        end
        ctrl_s_i = beats[0];
        ctrl_s_valid_i = 1'b1;
        for (i = 0; i <= s.count; i++) begin
            next_cycle();
            check_beat(s.exp_fwd, beats[i]);
            if (i < s.count) begin
                ctrl_s_i = beats[i + 1];
            end else begin
                ctrl_s_valid_i = 1'b0;
            end
            if (s.kind == S_WRITE && i > 0) begin
                // byte 0 is the high byte of the entry
                addr = idx[4:0] + 5'(i - 1);
                model[addr] = {beats[i].data[7:0], beats[i].data[15:8]};
                written_q.push_back(addr);
            end
        end
        // last write lands in the table on the second edge
        next_cycle();
        compare("ctrl_m_valid_o", ctrl_m_valid_o, 1'b0);
        next_cycle();
    endtask

    task automatic run_lookups(input int n);
        logic [1023:0] r;
        vlan_id_t      vlan;
        logic [4:0]    addr;
        int            i;
        for (i = 0; i < n; i++) begin
            addr = written_q.pop_front();
            rand_vec(r, 12);
            vlan = r[11:0];
            vlan[ADDR_LSB +: 5] = addr;
            compare("lookup_ready_o", lookup_ready_o, 1'b1);
            lookup_vlan_i = vlan;
            lookup_valid_i = 1'b1;
            next_cycle();
            lookup_valid_i = 1'b0;
            compare("lookup_ready_o", lookup_ready_o, 1'b0);
            compare("page_valid_o", page_valid_o, 1'b0);
            next_cycle();
            compare("page_valid_o", page_valid_o, 1'b0);
            next_cycle();
            compare("page_valid_o", page_valid_o, 1'b1);
            compare("page_o", page_o, model[addr]);
            compare("lookup_ready_o", lookup_ready_o, 1'b1);
            next_cycle();
            compare("page_valid_o", page_valid_o, 1'b0);
        end
    endtask

    // second phv arrives while the first is held and must be dropped
    task automatic run_phv(input int hold);
        logic [1023:0] r;
        phv_t          phv_a;
        vlan_id_t      exp_vlan;
        int            i;
        rand_vec(r, 1024);
        phv_a = r;
        exp_vlan = phv_a[VLAN_LSB +: 12];
        vlan_ready_i = 1'b0;
        phv_i = phv_a;
        phv_valid_i = 1'b1;
        next_cycle();
        compare("vlan_valid_o", vlan_valid_o, 1'b0);
        rand_vec(r, 1024);
        phv_i = r;
        next_cycle();
        phv_valid_i = 1'b0;
        compare("vlan_valid_o", vlan_valid_o, 1'b0);
        for (i = 0; i < hold; i++) begin
            next_cycle();
            compare("vlan_valid_o", vlan_valid_o, 1'b0);
        end
        vlan_ready_i = 1'b1;
        next_cycle();
        compare("vlan_valid_o", vlan_valid_o, 1'b1);
        compare("vlan_o", vlan_o, exp_vlan);
        for (i = 0; i < 3; i++) begin
            next_cycle();
            compare("vlan_valid_o", vlan_valid_o, 1'b0);
            compare("vlan_o", vlan_o, exp_vlan);
        end
    endtask

    initial begin
        int k;
        int c;
        rst_n = 1'b0;
        ctrl_s_i = '0;
        ctrl_s_valid_i = 1'b0;
        lookup_vlan_i = '0;
        lookup_valid_i = 1'b0;
        phv_i = '0;
        phv_valid_i = 1'b0;
        vlan_ready_i = 1'b1;
        build_table();
        repeat (3) @(posedge clk);
        #5;
        rst_n = 1'b1;
        compare("ctrl_m_valid_o", ctrl_m_valid_o, 1'b0);
        compare("page_valid_o", page_valid_o, 1'b0);
        compare("vlan_valid_o", vlan_valid_o, 1'b0);
        compare("lookup_ready_o", lookup_ready_o, 1'b1);
        for (k = 0; k < NUM_STEPS; k++) begin
            $display("step %0d: kind %0d count %0d", k, steps[k].kind, steps[k].count);
            case (steps[k].kind)
                S_BYPASS, S_WRITE: run_packet(steps[k]);
                S_LOOKUP: run_lookups(steps[k].count);
                S_PHV: run_phv(steps[k].count);
                default: begin
                    for (c = 0; c < steps[k].count; c++) begin
                        next_cycle();
                        compare("ctrl_m_valid_o", ctrl_m_valid_o, 1'b0);
                        compare("page_valid_o", page_valid_o, 1'b0);
                        compare("vlan_valid_o", vlan_valid_o, 1'b0);
                    end
                end
            endcase
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: action_engine.f
+incdir+rtl
rtl/ae_pkg.sv
rtl/ctrl_write_parser.sv
rtl/page_table.sv
rtl/vlan_extract.sv
rtl/action_engine.sv
sim/tb_action_engine.sv

// File: Bender.yml
package:
  name: action_engine

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/ae_pkg.sv
      - rtl/ctrl_write_parser.sv
      - rtl/page_table.sv
      - rtl/vlan_extract.sv
      - rtl/action_engine.sv
  - target: simulation
    files:
      - sim/tb_action_engine.sv
